/* rob_pkg.sv */
package rob_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int op_class_w = 2;

    // entry classes
    localparam logic [op_class_w-1:0] op_alu    = 2'd0;
    localparam logic [op_class_w-1:0] op_store  = 2'd1;
    localparam logic [op_class_w-1:0] op_branch = 2'd2;

    // major opcodes told apart by dispatch, all others are alu
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_jal    = 7'b1101111;

    // one instruction word seen through the R and S layouts
    typedef union packed {
        struct packed {
            logic [6:0]            funct7;
            logic [reg_addr_w-1:0] rs2;
            logic [reg_addr_w-1:0] rs1;
            logic [2:0]            funct3;
            logic [reg_addr_w-1:0] rd;
            logic [6:0]            opcode;
        } r_view;
        struct packed {
            logic [6:0]            imm_hi;
            logic [reg_addr_w-1:0] rs2;
            logic [reg_addr_w-1:0] rs1;
            logic [2:0]            funct3;
            logic [4:0]            imm_lo;
            logic [6:0]            opcode;
        } s_view;
    } instr_word_t;

endpackage

/* alloc_if.sv */
`timescale 1ns/100ps

interface alloc_if #(
    parameter int rob_depth = 16
);
    import rob_pkg::*;

    localparam int tag_w = $clog2(rob_depth);

    logic                  alloc_en;
    logic [op_class_w-1:0] op_class;
    logic [reg_addr_w-1:0] rd;
    logic                  pred_taken;
    logic [xlen-1:0]       pred_target;

    // from the buffer, next free slot and back-pressure
    logic [tag_w-1:0]      alloc_tag;
    logic                  full;

    modport producer (
        output alloc_en, op_class, rd, pred_taken, pred_target,
        input  alloc_tag, full
    );

    modport buffer (
        input  alloc_en, op_class, rd, pred_taken, pred_target,
        output alloc_tag, full
    );

endinterface

/* commit_if.sv */
`timescale 1ns/100ps

interface commit_if #(
    parameter int rob_depth = 16
);
    import rob_pkg::*;

    localparam int tag_w = $clog2(rob_depth);

    // oldest entry, offered for retirement
    logic                  head_valid;
    logic [op_class_w-1:0] head_class;
    logic [reg_addr_w-1:0] head_rd;
    logic [xlen-1:0]       head_data;
    logic [tag_w-1:0]      head_tag;
    logic                  head_mispredict;
    logic [xlen-1:0]       head_target;

    // back from the commit side
    logic                  retire;
    logic                  flush;

    modport buffer (
        output head_valid, head_class, head_rd, head_data, head_tag,
        output head_mispredict, head_target,
        input  retire, flush
    );

    modport consumer (
        input  head_valid, head_class, head_rd, head_data, head_tag,
        input  head_mispredict, head_target,
        output retire, flush
    );

endinterface

/* dispatch_unit.sv */
`timescale 1ns/100ps

module dispatch_unit #(
    parameter int  rob_depth = 16,
    localparam int tag_w     = $clog2(rob_depth)
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     instr_en,
    input  rob_pkg::instr_word_t     instr,
    input  logic                     pred_taken,
    input  logic [rob_pkg::xlen-1:0] pred_target,
    input  logic                     flush,
    alloc_if.producer                alloc
);
    import rob_pkg::*;

    logic [op_class_w-1:0] dec_class;
    logic [reg_addr_w-1:0] dec_rd;
    logic                  is_store;
    logic                  is_jal;

    // only sb, sh and sw count as stores
    assign is_store = (instr.s_view.opcode == opc_store) && (instr.s_view.funct3 < 3'd3);
    assign is_jal   = (instr.r_view.opcode == opc_jal);

    always_comb begin
        if (is_store) begin
            dec_class = op_store;
        end else if (is_jal || instr.r_view.opcode == opc_branch) begin
            dec_class = op_branch;
        end else begin
            dec_class = op_alu;
        end
    end

    // jal keeps its link register, stores and plain branches write nothing
    assign dec_rd = (dec_class == op_alu || is_jal) ? instr.r_view.rd : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            alloc.alloc_en <= 1'b0;
        end else begin
            // wrong-path request is dropped on flush
            alloc.alloc_en <= instr_en && !flush;
        end
    end

    always_ff @(posedge clk) begin
        if (instr_en) begin
            alloc.op_class    <= dec_class;
            alloc.rd          <= dec_rd;
            alloc.pred_taken  <= pred_taken;
            alloc.pred_target <= pred_target;
        end
    end

    // front end must hold off while the buffer reports full
    a_no_instr_when_full : assert property (
        @(posedge clk) disable iff (rst)
        instr_en |-> !alloc.full
    );

endmodule

/* reorder_buffer.sv */
`timescale 1ns/100ps

module reorder_buffer #(
    parameter int  rob_depth = 16,
    localparam int tag_w     = $clog2(rob_depth),
    localparam int cnt_w     = $clog2(rob_depth + 1)
) (
    input  logic                     clk,
    input  logic                     rst,
    alloc_if.buffer                  alloc,
    commit_if.buffer                 cmt,
    input  logic                     ex_en,
    input  logic [tag_w-1:0]         ex_tag,
    input  logic [rob_pkg::xlen-1:0] ex_data,
    input  logic                     ex_taken,
    input  logic [rob_pkg::xlen-1:0] ex_target,
    input  logic                     st_done,
    input  logic [tag_w-1:0]         st_done_tag
);
    import rob_pkg::*;

    // entry payload
    logic [op_class_w-1:0] cls     [rob_depth];
    logic [reg_addr_w-1:0] dst     [rob_depth];
    logic [xlen-1:0]       data    [rob_depth];
    logic [xlen-1:0]       target  [rob_depth];
    logic                  pred_tk [rob_depth];
    logic                  mispred [rob_depth];

    // entry state
    logic [rob_depth-1:0]  valid;
    logic [rob_depth-1:0]  done;
    logic [rob_depth-1:0]  released;

    logic [tag_w-1:0]      head;
    logic [tag_w-1:0]      tail;
    logic [tag_w-1:0]      head_inc;
    logic [tag_w-1:0]      tail_inc;
    logic [cnt_w-1:0]      count;
    logic                  head_is_store;
    logic                  pop;

    assign head_inc = (head == tag_w'(rob_depth - 1)) ? '0 : head + 1'b1;
    assign tail_inc = (tail == tag_w'(rob_depth - 1)) ? '0 : tail + 1'b1;

    // a request in flight already owns the tail slot
    assign alloc.alloc_tag = alloc.alloc_en ? tail_inc : tail;
    assign alloc.full      = (count == cnt_w'(rob_depth)) ||
                             (alloc.alloc_en && count == cnt_w'(rob_depth - 1));

    assign head_is_store = (cls[head] == op_store);

    // a store is offered once without a result, everything else waits for done
    assign cmt.head_valid      = valid[head] &&
                                 (head_is_store ? !released[head] : done[head]);
    assign cmt.head_class      = cls[head];
    assign cmt.head_rd         = dst[head];
    assign cmt.head_data       = data[head];
    assign cmt.head_tag        = head;
    assign cmt.head_mispredict = mispred[head];
    assign cmt.head_target     = target[head];

    assign pop = cmt.retire || st_done;

    always_ff @(posedge clk) begin
        if (rst || cmt.flush) begin
            valid    <= '0;
            done     <= '0;
            released <= '0;
            head     <= '0;
            tail     <= '0;
            count    <= '0;
        end else begin
            if (alloc.alloc_en) begin
                valid[tail]    <= 1'b1;
                done[tail]     <= 1'b0;
                released[tail] <= 1'b0;
                tail           <= tail_inc;
            end
            if (ex_en) begin
                done[ex_tag] <= 1'b1;
            end
            if (cmt.head_valid && head_is_store) begin
                released[head] <= 1'b1;
            end
            if (pop) begin
                valid[head] <= 1'b0;
                head        <= head_inc;
            end
            case ({alloc.alloc_en, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (alloc.alloc_en) begin
            cls[tail]     <= alloc.op_class;
            dst[tail]     <= alloc.rd;
            pred_tk[tail] <= alloc.pred_taken;
            target[tail]  <= alloc.pred_target;
            mispred[tail] <= 1'b0;
        end
        if (ex_en) begin
            data[ex_tag]    <= ex_data;
            // execution unit returns the real next pc, fall-through when not taken
            target[ex_tag]  <= ex_target;
            mispred[ex_tag] <= (cls[ex_tag] == op_branch) &&
                               ((ex_taken != pred_tk[ex_tag]) ||
                                (ex_taken && ex_target != target[ex_tag]));
        end
    end

    a_no_alloc_when_full : assert property (
        @(posedge clk) disable iff (rst)
        alloc.alloc_en && !cmt.flush |-> count != cnt_w'(rob_depth)
    );

    a_result_to_live_slot : assert property (
        @(posedge clk) disable iff (rst)
        ex_en && !cmt.flush |-> valid[ex_tag]
    );

    // store buffer may only complete the released store at the head
    a_st_done_at_head : assert property (
        @(posedge clk) disable iff (rst)
        st_done |-> st_done_tag == head && valid[head] && head_is_store && released[head]
    );

endmodule

/* commit_unit.sv */
`timescale 1ns/100ps

module commit_unit #(
    parameter int  rob_depth = 16,
    localparam int tag_w     = $clog2(rob_depth)
) (
    input  logic                           clk,
    input  logic                           rst,
    commit_if.consumer                     cmt,
    output logic                           rf_we,
    output logic [rob_pkg::reg_addr_w-1:0] rf_rd,
    output logic [rob_pkg::xlen-1:0]       rf_data,
    output logic                           store_release,
    output logic [tag_w-1:0]               store_tag,
    output logic                           flush,
    output logic [rob_pkg::xlen-1:0]       redirect_pc
);
    import rob_pkg::*;

    localparam int num_regs = 1 << reg_addr_w;

    // architectural registers
    logic [xlen-1:0] regs [num_regs];

    logic take;
    logic is_store;
    logic wr_reg;

    // nothing is taken while the flush is still in flight
    assign take     = cmt.head_valid && !flush;
    assign is_store = (cmt.head_class == op_store);
    assign wr_reg   = take && !is_store && (cmt.head_rd != '0);

    assign cmt.retire = take && !is_store;
    assign cmt.flush  = flush;

    assign rf_data = regs[rf_rd];

    always_ff @(posedge clk) begin
        if (rst) begin
            rf_we         <= 1'b0;
            store_release <= 1'b0;
            flush         <= 1'b0;
        end else begin
            rf_we         <= wr_reg;
            store_release <= take && is_store;
            flush         <= take && !is_store && cmt.head_mispredict;
        end
    end

    // x0 is never written
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_reg) begin
            regs[cmt.head_rd] <= cmt.head_data;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_reg) begin
            rf_rd <= cmt.head_rd;
        end
        if (take && is_store) begin
            store_tag <= cmt.head_tag;
        end
        if (take && !is_store && cmt.head_mispredict) begin
            redirect_pc <= cmt.head_target;
        end
    end

    // a store at the head is released once, never on two cycles running
    a_release_single_pulse : assert property (
        @(posedge clk) disable iff (rst)
        store_release |=> !store_release
    );

endmodule

/* rob_top.sv */
`timescale 1ns/100ps

module rob_top #(
    parameter int  rob_depth = 16,
    localparam int tag_w     = $clog2(rob_depth)
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           instr_en,
    input  logic [rob_pkg::xlen-1:0]       instr,
    input  logic                           instr_pred_taken,
    input  logic [rob_pkg::xlen-1:0]       instr_pred_target,
    output logic                           full,
    output logic [tag_w-1:0]               instr_tag,
    input  logic                           ex_en,
    input  logic [tag_w-1:0]               ex_tag,
    input  logic [rob_pkg::xlen-1:0]       ex_data,
    input  logic                           ex_taken,
    input  logic [rob_pkg::xlen-1:0]       ex_target,
    input  logic                           st_done,
    input  logic [tag_w-1:0]               st_done_tag,
    output logic                           rf_we,
    output logic [rob_pkg::reg_addr_w-1:0] rf_rd,
    output logic [rob_pkg::xlen-1:0]       rf_data,
    output logic                           store_release,
    output logic [tag_w-1:0]               store_tag,
    output logic                           flush,
    output logic [rob_pkg::xlen-1:0]       redirect_pc
);

    alloc_if  #(.rob_depth(rob_depth)) alloc_bus ();
    commit_if #(.rob_depth(rob_depth)) cmt_bus ();

    // tag handed back to the front end in the cycle it offers the instruction
    assign full      = alloc_bus.full;
    assign instr_tag = alloc_bus.alloc_tag;

    dispatch_unit #(.rob_depth(rob_depth)) u_dispatch (
        .clk         (clk),
        .rst         (rst),
        .instr_en    (instr_en),
        .instr       (instr),
        .pred_taken  (instr_pred_taken),
        .pred_target (instr_pred_target),
        .flush       (flush),
        .alloc       (alloc_bus.producer)
    );

    reorder_buffer #(.rob_depth(rob_depth)) u_rob (
        .clk         (clk),
        .rst         (rst),
        .alloc       (alloc_bus.buffer),
        .cmt         (cmt_bus.buffer),
        .ex_en       (ex_en),
        .ex_tag      (ex_tag),
        .ex_data     (ex_data),
        .ex_taken    (ex_taken),
        .ex_target   (ex_target),
        .st_done     (st_done),
        .st_done_tag (st_done_tag)
    );

    commit_unit #(.rob_depth(rob_depth)) u_commit (
        .clk           (clk),
        .rst           (rst),
        .cmt           (cmt_bus.consumer),
        .rf_we         (rf_we),
        .rf_rd         (rf_rd),
        .rf_data       (rf_data),
        .store_release (store_release),
        .store_tag     (store_tag),
        .flush         (flush),
        .redirect_pc   (redirect_pc)
    );

endmodule

/* rob_checker.sv */
`timescale 1ns/100ps

module rob_checker #(
    parameter int tag_w = 4
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             rf_we,
    input  logic [4:0]       rf_rd,
    input  logic [31:0]      rf_data,
    input  logic             store_release,
    input  logic [tag_w-1:0] store_tag,
    input  logic             flush,
    input  logic [31:0]      redirect_pc,
    input  logic             full,
    input  logic             st_done,
    input  logic             probe,
    input  logic             test_end,
    output logic             drained,
    output int               errors
);

    localparam int max_exp = 64;

    // expected events in order, W write, R release, L flush, F full level
    logic [7:0]  ek [max_exp];
    logic [31:0] ea [max_exp];
    logic [31:0] eb [max_exp];
    int          tstart [16];
    int          ne;
    int          ntests;
    int          cur;
    int          ptr;
    int          tend_cur;
    int          test_errs;
    int          passed;
    int          failed;
    int          checks;
    logic        store_open;

    assign drained = (ptr >= tend_cur);

    initial begin
        int          fh;
        int          got;
        int          c;
        logic [7:0]  ch;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] x;
        logic [31:0] y;
        ne = 0;
        ntests = 0;
        errors = 0;
        test_errs = 0;
        passed = 0;
        failed = 0;
        checks = 0;
        store_open = 1'b0;
        fh = $fopen("rob_stim.txt", "r");
        if (fh != 0) begin
            while ($fscanf(fh, " %c", ch) == 1) begin
                a = '0;
                b = '0;
                case (ch)
                    "#": begin
                        c = $fgetc(fh);
                        while (c != 10 && c != -1) c = $fgetc(fh);
                    end
                    "t": begin
                        got = $fscanf(fh, "%h", a);
                        tstart[ntests] = ne;
                        ntests++;
                    end
                    "i", "r": got = $fscanf(fh, "%h %h %h %h", a, b, x, y);
                    "s", "w": got = $fscanf(fh, "%h", a);
                    "W", "R", "L", "F": begin
                        if (ch == "W") got = $fscanf(fh, "%h %h", a, b);
                        else got = $fscanf(fh, "%h", a);
                        ek[ne] = ch;
                        ea[ne] = a;
                        eb[ne] = b;
                        ne++;
                    end
                    default: ;
                endcase
            end
            $fclose(fh);
        end
        cur = 0;
        ptr = 0;
        tend_cur = (ntests > 1) ? tstart[1] : ne;
    end

    task automatic expect_event(input logic [7:0] kind, input logic [31:0] a,
                                input logic [31:0] b);
        checks++;
        if (ptr >= tend_cur) begin
            $display("unexpected %c event with value %0h at time %0t", kind, a, $time);
            test_errs++;
            errors++;
        end else begin
            if (ek[ptr] != kind || ea[ptr] != a || (kind == "W" && eb[ptr] != b)) begin
                $display("[FAIL] %0t: expected %c %0h %0h, got %c %0h %0h", $time,
                         ek[ptr], ea[ptr], eb[ptr], kind, a, b);
                test_errs++;
                errors++;
            end
            ptr++;
        end
    endtask

    task automatic finish_test();
        if (test_errs == 0) begin
            passed++;
            $display("test %0d passed", cur + 1);
        end else begin
            failed++;
            $display("test %0d failed with %0d errors", cur + 1, test_errs);
        end
        test_errs = 0;
        cur++;
        if (cur < ntests) begin
            ptr = tstart[cur];
            tend_cur = (cur + 1 < ntests) ? tstart[cur + 1] : ne;
        end else begin
            $display("%0d tests passed, %0d failed, %0d checks, %0d errors",
                     passed, failed, checks, errors);
        end
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            if (rf_we) begin
                // younger entries stay behind an unfinished store
                if (store_open) begin
                    $display("register write at time %0t while a store was outstanding",
                             $time);
                    test_errs++;
                    errors++;
                end
                expect_event("W", rf_rd, rf_data);
            end
            if (store_release) begin
                expect_event("R", store_tag, '0);
                store_open = 1'b1;
            end
            if (st_done) store_open = 1'b0;
            if (flush) expect_event("L", redirect_pc, '0);
            if (probe) expect_event("F", full, '0);
            if (test_end) finish_test();
        end
    end

endmodule

/* tb_rob_top.sv */
`timescale 1ns/100ps

module tb_rob_top;

    localparam int rob_depth = 16;
    localparam int tag_w     = $clog2(rob_depth);
    localparam int max_rec   = 128;

    logic             clk;
    logic             rst;
    logic             instr_en;
    logic [31:0]      instr;
    logic             instr_pred_taken;
    logic [31:0]      instr_pred_target;
    logic             full;
    logic [tag_w-1:0] instr_tag;
    logic             ex_en;
    logic [tag_w-1:0] ex_tag;
    logic [31:0]      ex_data;
    logic             ex_taken;
    logic [31:0]      ex_target;
    logic             st_done;
    logic [tag_w-1:0] st_done_tag;
    logic             rf_we;
    logic [4:0]       rf_rd;
    logic [31:0]      rf_data;
    logic             store_release;
    logic [tag_w-1:0] store_tag;
    logic             flush;
    logic [31:0]      redirect_pc;
    logic             probe;
    logic             test_end;
    logic             drained;
    int               errors;

    // stim records, one kind letter and up to four hex fields
    logic [7:0]       rk [max_rec];
    logic [31:0]      fa [max_rec];
    logic [31:0]      fb [max_rec];
    logic [31:0]      fc [max_rec];
    logic [31:0]      fd [max_rec];
    int               nrec;

    logic [tag_w-1:0] tag_of [32];
    int               nidx;
    int               pend [$];
    int               seed;
    int               cycles = 0;
    int               limit = 1000000;
    int               rel_seen = 0;
    int               rel_used;

    rob_top #(.rob_depth(rob_depth)) u_dut (
        .clk               (clk),
        .rst               (rst),
        .instr_en          (instr_en),
        .instr             (instr),
        .instr_pred_taken  (instr_pred_taken),
        .instr_pred_target (instr_pred_target),
        .full              (full),
        .instr_tag         (instr_tag),
        .ex_en             (ex_en),
        .ex_tag            (ex_tag),
        .ex_data           (ex_data),
        .ex_taken          (ex_taken),
        .ex_target         (ex_target),
        .st_done           (st_done),
        .st_done_tag       (st_done_tag),
        .rf_we             (rf_we),
        .rf_rd             (rf_rd),
        .rf_data           (rf_data),
        .store_release     (store_release),
        .store_tag         (store_tag),
        .flush             (flush),
        .redirect_pc       (redirect_pc)
    );

    rob_checker #(.tag_w(tag_w)) u_checker (
        .clk           (clk),
        .rst           (rst),
        .rf_we         (rf_we),
        .rf_rd         (rf_rd),
        .rf_data       (rf_data),
        .store_release (store_release),
        .store_tag     (store_tag),
        .flush         (flush),
        .redirect_pc   (redirect_pc),
        .full          (full),
        .st_done       (st_done),
        .probe         (probe),
        .test_end      (test_end),
        .drained       (drained),
        .errors        (errors)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            $display("timeout: the run did not finish within %0d cycles", limit);
            $display("Simulation failed");
            $finish;
        end
    end

    // store buffer model counts releases seen on the port
    always @(negedge clk) begin
        if (!rst && store_release) begin
            rel_seen <= rel_seen + 1;
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        instr_en <= 1'b0;
        ex_en    <= 1'b0;
        st_done  <= 1'b0;
        probe    <= 1'b0;
        test_end <= 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n) next_cycle();
    endtask

    task automatic issue(input int n);
        next_cycle();
        instr_en          <= 1'b1;
        instr             <= fa[n];
        instr_pred_taken  <= fb[n][0];
        instr_pred_target <= fc[n];
        @(negedge clk);
        tag_of[nidx] = instr_tag;
        nidx++;
    endtask

    // execution units return the collected results in random order
    task automatic send_results();
        int j;
        int tmp;
        for (int k = pend.size() - 1; k > 0; k--) begin
            j       = $unsigned($random(seed)) % (k + 1);
            tmp     = pend[k];
            pend[k] = pend[j];
            pend[j] = tmp;
        end
        // the last request is still being allocated
        next_cycle();
        foreach (pend[k]) begin
            next_cycle();
            ex_en     <= 1'b1;
            ex_tag    <= tag_of[fa[pend[k]]];
            ex_data   <= fb[pend[k]];
            ex_taken  <= fc[pend[k]][0];
            ex_target <= fd[pend[k]];
        end
        pend.delete();
    endtask

    task automatic complete_store(input int idx);
        while (rel_seen <= rel_used) next_cycle();
        rel_used++;
        idle(3);
        next_cycle();
        st_done     <= 1'b1;
        st_done_tag <= tag_of[idx];
    endtask

    task automatic close_test();
        next_cycle();
        while (!drained) next_cycle();
        idle(4);
        next_cycle();
        test_end <= 1'b1;
    endtask

    task automatic load_stim(output bit ok);
        int         fh;
        int         got;
        int         c;
        logic [7:0] ch;
        fh   = $fopen("rob_stim.txt", "r");
        ok   = (fh != 0);
        nrec = 0;
        if (ok) begin
            while ($fscanf(fh, " %c", ch) == 1) begin
                fa[nrec] = '0;
                fb[nrec] = '0;
                fc[nrec] = '0;
                fd[nrec] = '0;
                rk[nrec] = ch;
                case (ch)
                    "#": begin
                        c = $fgetc(fh);
                        while (c != 10 && c != -1) c = $fgetc(fh);
                        nrec--;
                    end
                    "i", "r": got = $fscanf(fh, "%h %h %h %h", fa[nrec], fb[nrec],
                                            fc[nrec], fd[nrec]);
                    "W":      got = $fscanf(fh, "%h %h", fa[nrec], fb[nrec]);
                    "g", "p": got = 0;
                    default:  got = $fscanf(fh, "%h", fa[nrec]);
                endcase
                nrec++;
            end
            $fclose(fh);
        end
    endtask

    initial begin
        bit ok;
        bit started;
        rst               = 1'b1;
        instr_en          = 1'b0;
        instr             = '0;
        instr_pred_taken  = 1'b0;
        instr_pred_target = '0;
        ex_en             = 1'b0;
        ex_tag            = '0;
        ex_data           = '0;
        ex_taken          = 1'b0;
        ex_target         = '0;
        st_done           = 1'b0;
        st_done_tag       = '0;
        probe             = 1'b0;
        test_end          = 1'b0;
        seed              = 64;
        rel_used          = 0;
        nidx              = 0;
        started           = 1'b0;
        load_stim(ok);
        if (!ok) begin
            $display("could not open rob_stim.txt");
            $display("Simulation failed");
            $finish;
        end else begin
            limit = nrec * 20 + 100;
            repeat (16) @(posedge clk);
            rst <= 1'b0;
            for (int n = 0; n < nrec; n++) begin
                case (rk[n])
                    "t": begin
                        if (started) close_test();
                        started = 1'b1;
                        nidx    = 0;
                    end
                    "i": repeat (fd[n]) issue(n);
                    "r": pend.push_back(n);
                    "g": send_results();
                    "s": complete_store(fa[n]);
                    "w": idle(fa[n]);
                    "p": begin
                        next_cycle();
                        probe <= 1'b1;
                    end
                    default: ;
                endcase
            end
            close_test();
            idle(2);
            if (errors == 0) begin
                $display("Simulation completed successfully");
            end else begin
                $display("Simulation failed");
            end
            $finish;
        end
    end

endmodule

/* rob_stim.txt */
# t test | i word pred_taken pred_target count | r idx data taken target | g send results
# s store idx | w cycles | p probe | expect: W rd data, R tag, L redirect, F full
t 1
i 00000093 0 0 1
i 00000113 0 0 1
i 00000193 0 0 1
i 00000213 0 0 1
r 0 11 0 0
r 1 22 0 0
r 2 33 0 0
r 3 44 0 0
g
W 1 11
W 2 22
W 3 33
W 4 44
t 2
i 00000063 0 0 1
i 00000293 0 0 f
w 3
p
F 1
r 0 0 1 100
g
w 6
p
L 100
F 0
t 3
i 00000313 0 0 1
i 00002023 0 0 1
i 00000393 0 0 1
r 0 66 0 0
r 2 77 0 0
g
s 1
W 6 66
R 1
W 7 77
t 4
i 000000ef 0 0 1
i 00000413 0 0 1
i 00000493 0 0 1
r 1 88 0 0
r 2 99 0 0
r 0 104 1 200
g
w 6
i 00000513 0 0 1
r 3 aa 0 0
g
W 1 104
L 200
W a aa
t 5
i 00000063 1 300 1
i 00000013 0 0 1
i 00000593 0 0 1
r 0 0 1 300
r 1 5a5a 0 0
r 2 bb 0 0
g
W b bb

/* files.f */
rob_pkg.sv
alloc_if.sv
commit_if.sv
dispatch_unit.sv
reorder_buffer.sv
commit_unit.sv
rob_top.sv
rob_checker.sv
tb_rob_top.sv
